// ==== all.f ====
+incdir+verilog
verilog/xbar_pkg.sv
verilog/xbar_route_if.sv
verilog/rr_arbiter.sv
verilog/chan_mux.sv
verilog/ar_request_unit.sv
verilog/r_return_unit.sv
verilog/axi_read_xbar.sv
bench/tb_slave_model.sv
bench/tb_axi_read_xbar.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
FILE_LIST = all.f
TB_TOP    = tb_axi_read_xbar
RTL_TOP   = axi_read_xbar
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_axi_read_xbar.sv ====
// ==========================================================
// Testbench of the AXI read crossbar with two slave models
// ==========================================================
`timescale 1ns/1ns
`include "xbar_settings.svh"

module tb_axi_read_xbar
	import xbar_pkg::*;
();
	localparam int AW = `XBAR_ADDR_WIDTH;
	localparam int DW = `XBAR_DATA_WIDTH;
	localparam int IW = `XBAR_ID_WIDTH;
	localparam int LW = `XBAR_LEN_WIDTH;
	localparam int HW = DW - AW;
	localparam int CLK_NS = 8;
	localparam int RESET_CYCLES = 16;
	// 20 bursts of at most 8 beats, 16 cycles allowed per beat
	localparam int WATCHDOG_NS = (RESET_CYCLES + 20 * 8 * 16) * CLK_NS;

	typedef enum int {MODE_DECODE, MODE_SAME, MODE_SPLIT, MODE_RANDOM} mode_t;

	logic          clk;
	logic          rstn;
	logic          m_ar_valid [2];
	logic [AW-1:0] m_ar_addr [2];
	logic [IW-1:0] m_ar_id [2];
	logic [LW-1:0] m_ar_len [2];
	logic          m_ar_ready [2];
	logic          m_r_valid [2];
	logic [IW-1:0] m_r_id [2];
	logic [DW-1:0] m_r_data [2];
	logic [1:0]    m_r_resp [2];
	logic          m_r_last [2];
	logic          m_r_ready [2];

	logic          s_ar_valid [2];
	logic [AW-1:0] s_ar_addr [2];
	tagged_id_t    s_ar_id [2];
	logic [LW-1:0] s_ar_len [2];
	logic          s_ar_ready [2];
	logic          s_r_valid [2];
	tagged_id_t    s_r_id [2];
	logic [DW-1:0] s_r_data [2];
	logic [1:0]    s_r_resp [2];
	logic          s_r_last [2];
	logic          s_r_ready [2];

	// Stimulus tables of the running test and the read in flight per master
	logic [AW-1:0] tab_addr [2][8];
	logic [IW-1:0] tab_id [2][8];
	logic [LW-1:0] tab_len [2][8];
	logic [AW-1:0] exp_addr [2];
	logic [IW-1:0] exp_id [2];
	logic [LW-1:0] exp_len [2];
	logic [LW-1:0] beat_cnt [2] = '{8'd0, 8'd0};
	int            issued [2] = '{0, 0};
	int            done [2] = '{0, 0};
	integer        stim_seed = 32'haad41b8c;
	integer        ready_seed = 32'haad41b8c;
	bit            stall_on = 1'b0;
	string         test_name = "reset";

	axi_read_xbar i_axi_read_xbar (
		.clk(clk), .rstn(rstn),
		.m0_ar_valid_i(m_ar_valid[0]), .m0_ar_addr_i(m_ar_addr[0]),
		.m0_ar_id_i(m_ar_id[0]), .m0_ar_len_i(m_ar_len[0]), .m0_ar_ready_o(m_ar_ready[0]),
		.m0_r_valid_o(m_r_valid[0]), .m0_r_id_o(m_r_id[0]), .m0_r_data_o(m_r_data[0]),
		.m0_r_resp_o(m_r_resp[0]), .m0_r_last_o(m_r_last[0]), .m0_r_ready_i(m_r_ready[0]),
		.m1_ar_valid_i(m_ar_valid[1]), .m1_ar_addr_i(m_ar_addr[1]),
		.m1_ar_id_i(m_ar_id[1]), .m1_ar_len_i(m_ar_len[1]), .m1_ar_ready_o(m_ar_ready[1]),
		.m1_r_valid_o(m_r_valid[1]), .m1_r_id_o(m_r_id[1]), .m1_r_data_o(m_r_data[1]),
		.m1_r_resp_o(m_r_resp[1]), .m1_r_last_o(m_r_last[1]), .m1_r_ready_i(m_r_ready[1]),
		.s0_ar_valid_o(s_ar_valid[0]), .s0_ar_addr_o(s_ar_addr[0]), .s0_ar_id_o(s_ar_id[0]),
		.s0_ar_len_o(s_ar_len[0]), .s0_ar_ready_i(s_ar_ready[0]),
		.s0_r_valid_i(s_r_valid[0]), .s0_r_id_i(s_r_id[0]), .s0_r_data_i(s_r_data[0]),
		.s0_r_resp_i(s_r_resp[0]), .s0_r_last_i(s_r_last[0]), .s0_r_ready_o(s_r_ready[0]),
		.s1_ar_valid_o(s_ar_valid[1]), .s1_ar_addr_o(s_ar_addr[1]), .s1_ar_id_o(s_ar_id[1]),
		.s1_ar_len_o(s_ar_len[1]), .s1_ar_ready_i(s_ar_ready[1]),
		.s1_r_valid_i(s_r_valid[1]), .s1_r_id_i(s_r_id[1]), .s1_r_data_i(s_r_data[1]),
		.s1_r_resp_i(s_r_resp[1]), .s1_r_last_i(s_r_last[1]), .s1_r_ready_o(s_r_ready[1])
	);

	for (genvar s = 0; s < 2; s++) begin : g_slave
		tb_slave_model #(.SLAVE_IDX(s), .SEED(32'haad41b8c)) i_slave (
			.clk(clk), .rstn(rstn),
			.ar_valid_i(s_ar_valid[s]), .ar_addr_i(s_ar_addr[s]), .ar_id_i(s_ar_id[s]),
			.ar_len_i(s_ar_len[s]), .ar_ready_o(s_ar_ready[s]),
			.r_valid_o(s_r_valid[s]), .r_id_o(s_r_id[s]), .r_data_o(s_r_data[s]),
			.r_resp_o(s_r_resp[s]), .r_last_o(s_r_last[s]), .r_ready_i(s_r_ready[s])
		);
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// Beat k of a read: slave index from the top address bit above the beat address
	function automatic logic [DW-1:0] expected_beat(input logic [AW-1:0] addr,
			input logic [LW-1:0] k);
		logic [AW-1:0] beat_addr;
		beat_addr = addr + (AW'(k) << 3);
		return {HW'(addr[AW-1]), beat_addr};
	endfunction

	function automatic logic target_slave(input mode_t mode, input int mi, input int i,
			input logic coin);
		case (mode)
			MODE_DECODE: return (i % 2) == 1;
			MODE_SAME: return 1'b0;
			MODE_SPLIT: return ((mi + i) % 2) == 1;
			default: return coin;
		endcase
	endfunction

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string what, input logic [DW-1:0] expected,
			input logic [DW-1:0] actual);
		$display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
		abort_run();
	endtask

	task automatic report_problem(input string why);
		$display("Error [%s]: %s", test_name, why);
		abort_run();
	endtask

	// One read at a time, the next one waits for the last beat of the previous
	task automatic run_master(input int mi, input int count);
		for (int i = 0; i < count; i++) begin
			while (done[mi] != issued[mi]) @(posedge clk);
			exp_addr[mi] <= tab_addr[mi][i];
			exp_id[mi] <= tab_id[mi][i];
			exp_len[mi] <= tab_len[mi][i];
			issued[mi] <= issued[mi] + 1;
			m_ar_valid[mi] <= 1'b1;
			m_ar_addr[mi] <= tab_addr[mi][i];
			m_ar_id[mi] <= tab_id[mi][i];
			m_ar_len[mi] <= tab_len[mi][i];
			@(posedge clk);
			while (!m_ar_ready[mi]) @(posedge clk);
			m_ar_valid[mi] <= 1'b0;
		end
		while (done[mi] != issued[mi]) @(posedge clk);
	endtask

	task automatic run_phase(input string name, input mode_t mode, input int count,
			input bit stall);
		integer rnd;
		test_name = name;
		stall_on <= stall;
		for (int mi = 0; mi < 2; mi++) begin
			for (int i = 0; i < count; i++) begin
				rnd = $random(stim_seed);
				tab_addr[mi][i] = {target_slave(mode, mi, i, rnd[31]), rnd[AW-2:0]};
				rnd = $random(stim_seed);
				tab_id[mi][i] = rnd[IW-1:0];
				tab_len[mi][i] = {5'b0, rnd[10:8]};
			end
		end
		fork
			run_master(0, count);
			run_master(1, count);
		join
	endtask

	// Master read-data ready, randomly low while stalls are on
	initial begin
		integer draw;
		m_r_ready[0] = 1'b0;
		m_r_ready[1] = 1'b0;
		forever begin
			@(posedge clk);
			draw = $random(ready_seed);
			m_r_ready[0] <= stall_on ? draw[0] : 1'b1;
			m_r_ready[1] <= stall_on ? draw[1] : 1'b1;
		end
	end

	for (genvar g = 0; g < 2; g++) begin : g_check
		always @(posedge clk) begin : compare
			logic [DW-1:0] exp_data;
			logic          exp_last;
			if (rstn && m_r_valid[g] && m_r_ready[g]) begin
				assert (issued[g] != done[g]) else
					report_problem($sformatf("m%0d got a read beat with no read outstanding", g));
				exp_data = expected_beat(exp_addr[g], beat_cnt[g]);
				exp_last = (beat_cnt[g] == exp_len[g]);
				assert (m_r_data[g] == exp_data) else
					report_mismatch($sformatf("m%0d r_data_o", g), exp_data, m_r_data[g]);
				assert (m_r_id[g] == exp_id[g]) else
					report_mismatch($sformatf("m%0d r_id_o", g), DW'(exp_id[g]), DW'(m_r_id[g]));
				assert (m_r_resp[g] == 2'b00) else
					report_mismatch($sformatf("m%0d r_resp_o", g), '0, DW'(m_r_resp[g]));
				assert (m_r_last[g] == exp_last) else
					report_mismatch($sformatf("m%0d r_last_o", g), DW'(exp_last), DW'(m_r_last[g]));
				if (exp_last) begin
					beat_cnt[g] <= '0;
					done[g] <= done[g] + 1;
				end else begin
					beat_cnt[g] <= beat_cnt[g] + 1'b1;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		report_problem($sformatf("timeout after %0d ns with reads still open", WATCHDOG_NS));
	end

	initial begin
		rstn = 1'b0;
		for (int mi = 0; mi < 2; mi++) begin
			m_ar_valid[mi] = 1'b0;
			m_ar_addr[mi] = '0;
			m_ar_id[mi] = '0;
			m_ar_len[mi] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		for (int mi = 0; mi < 2; mi++) begin
			assert (m_ar_ready[mi] == 1'b1) else
				report_mismatch($sformatf("m%0d ar_ready_o", mi), DW'(1), DW'(m_ar_ready[mi]));
			assert (m_r_valid[mi] == 1'b0) else
				report_mismatch($sformatf("m%0d r_valid_o", mi), '0, DW'(m_r_valid[mi]));
		end
		run_phase("decode", MODE_DECODE, 2, 1'b0);
		run_phase("contention", MODE_SAME, 3, 1'b0);
		run_phase("parallel", MODE_SPLIT, 2, 1'b0);
		run_phase("backpressure", MODE_RANDOM, 3, 1'b1);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== bench/tb_slave_model.sv ====
// ==========================================================
// Behavioral AXI read slave, data derived from the address
// ==========================================================
`timescale 1ns/1ns
`include "xbar_settings.svh"

module tb_slave_model
	import xbar_pkg::*;
#(
	parameter int          SLAVE_IDX = 0,
	parameter logic [31:0] SEED      = 32'h0
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        ar_valid_i,
	input  logic [`XBAR_ADDR_WIDTH-1:0] ar_addr_i,
	input  tagged_id_t                  ar_id_i,
	input  logic [`XBAR_LEN_WIDTH-1:0]  ar_len_i,
	output logic                        ar_ready_o,
	output logic                        r_valid_o,
	output tagged_id_t                  r_id_o,
	output logic [`XBAR_DATA_WIDTH-1:0] r_data_o,
	output logic [1:0]                  r_resp_o,
	output logic                        r_last_o,
	input  logic                        r_ready_i
);
	integer      seed;
	integer      rnd;
	logic [31:0] addr_q;
	tagged_id_t  id_q;
	logic [7:0]  len_q;
	logic [7:0]  beat;
	logic        last;

	initial begin
		seed = SEED + SLAVE_IDX;
		ar_ready_o = 1'b0;
		r_valid_o = 1'b0;
		r_id_o = '0;
		r_data_o = '0;
		r_resp_o = 2'b00;
		r_last_o = 1'b0;
		forever begin
			@(posedge clk);
			if (rstn && ar_valid_i) begin
				// Random 0 to 3 cycle wait before taking the address
				rnd = $random(seed);
				repeat (rnd[1:0]) @(posedge clk);
				ar_ready_o <= 1'b1;
				@(posedge clk);
				addr_q = ar_addr_i;
				id_q = ar_id_i;
				len_q = ar_len_i;
				ar_ready_o <= 1'b0;
				beat = '0;
				last = 1'b0;
				while (!last) begin
					last = (beat == len_q);
					r_valid_o <= 1'b1;
					r_id_o <= id_q;
					r_data_o <= {32'(SLAVE_IDX), addr_q + (32'(beat) << 3)};
					r_resp_o <= 2'b00;
					r_last_o <= last;
					@(posedge clk);
					while (!r_ready_i) @(posedge clk);
					beat = beat + 1'b1;
				end
				r_valid_o <= 1'b0;
				r_last_o <= 1'b0;
			end
		end
	end

endmodule

// ==== verilog/axi_read_xbar.sv ====
// ==========================================================
// Two-master, two-slave AXI4 read crossbar top level
// ==========================================================
`timescale 1ns/1ns
`include "xbar_settings.svh"

module axi_read_xbar
	import xbar_pkg::*;
(
	input  logic                        clk,
	input  logic                        rstn,

	input  logic                        m0_ar_valid_i,
	input  logic [`XBAR_ADDR_WIDTH-1:0] m0_ar_addr_i,
	input  logic [`XBAR_ID_WIDTH-1:0]   m0_ar_id_i,
	input  logic [`XBAR_LEN_WIDTH-1:0]  m0_ar_len_i,
	output logic                        m0_ar_ready_o,
	output logic                        m0_r_valid_o,
	output logic [`XBAR_ID_WIDTH-1:0]   m0_r_id_o,
	output logic [`XBAR_DATA_WIDTH-1:0] m0_r_data_o,
	output logic [1:0]                  m0_r_resp_o,
	output logic                        m0_r_last_o,
	input  logic                        m0_r_ready_i,

	input  logic                        m1_ar_valid_i,
	input  logic [`XBAR_ADDR_WIDTH-1:0] m1_ar_addr_i,
	input  logic [`XBAR_ID_WIDTH-1:0]   m1_ar_id_i,
	input  logic [`XBAR_LEN_WIDTH-1:0]  m1_ar_len_i,
	output logic                        m1_ar_ready_o,
	output logic                        m1_r_valid_o,
	output logic [`XBAR_ID_WIDTH-1:0]   m1_r_id_o,
	output logic [`XBAR_DATA_WIDTH-1:0] m1_r_data_o,
	output logic [1:0]                  m1_r_resp_o,
	output logic                        m1_r_last_o,
	input  logic                        m1_r_ready_i,

	output logic                        s0_ar_valid_o,
	output logic [`XBAR_ADDR_WIDTH-1:0] s0_ar_addr_o,
	output tagged_id_t                  s0_ar_id_o,
	output logic [`XBAR_LEN_WIDTH-1:0]  s0_ar_len_o,
	input  logic                        s0_ar_ready_i,
	input  logic                        s0_r_valid_i,
	input  tagged_id_t                  s0_r_id_i,
	input  logic [`XBAR_DATA_WIDTH-1:0] s0_r_data_i,
	input  logic [1:0]                  s0_r_resp_i,
	input  logic                        s0_r_last_i,
	output logic                        s0_r_ready_o,

	output logic                        s1_ar_valid_o,
	output logic [`XBAR_ADDR_WIDTH-1:0] s1_ar_addr_o,
	output tagged_id_t                  s1_ar_id_o,
	output logic [`XBAR_LEN_WIDTH-1:0]  s1_ar_len_o,
	input  logic                        s1_ar_ready_i,
	input  logic                        s1_r_valid_i,
	input  tagged_id_t                  s1_r_id_i,
	input  logic [`XBAR_DATA_WIDTH-1:0] s1_r_data_i,
	input  logic [1:0]                  s1_r_resp_i,
	input  logic                        s1_r_last_i,
	output logic                        s1_r_ready_o
);
	ar_req_t s_ar [`XBAR_N_SLAVES];
	r_beat_t s_beat [`XBAR_N_SLAVES];
	r_beat_t m_beat [`XBAR_N_MASTERS];

	// One routed channel per source unit
	xbar_route_if #(.T(ar_req_t), .D(slave_idx_t)) ar_route [`XBAR_N_MASTERS] ();
	xbar_route_if #(.T(r_beat_t), .D(master_idx_t)) r_route [`XBAR_N_SLAVES] ();

	// Request side, one unit per master
	ar_request_unit #(.MASTER_IDX(0)) i_ar_m0 (
		.clk(clk), .rstn(rstn),
		.ar_valid_i(m0_ar_valid_i), .ar_addr_i(m0_ar_addr_i),
		.ar_id_i(m0_ar_id_i), .ar_len_i(m0_ar_len_i),
		.ar_ready_o(m0_ar_ready_o), .route(ar_route[0])
	);

	ar_request_unit #(.MASTER_IDX(1)) i_ar_m1 (
		.clk(clk), .rstn(rstn),
		.ar_valid_i(m1_ar_valid_i), .ar_addr_i(m1_ar_addr_i),
		.ar_id_i(m1_ar_id_i), .ar_len_i(m1_ar_len_i),
		.ar_ready_o(m1_ar_ready_o), .route(ar_route[1])
	);

	chan_mux #(.T(ar_req_t), .N_SRC(`XBAR_N_MASTERS), .DEST_IDX(0)) i_ar_mux_s0 (
		.clk(clk), .rstn(rstn), .src(ar_route),
		.valid_o(s0_ar_valid_o), .payload_o(s_ar[0]), .ready_i(s0_ar_ready_i)
	);

	chan_mux #(.T(ar_req_t), .N_SRC(`XBAR_N_MASTERS), .DEST_IDX(1)) i_ar_mux_s1 (
		.clk(clk), .rstn(rstn), .src(ar_route),
		.valid_o(s1_ar_valid_o), .payload_o(s_ar[1]), .ready_i(s1_ar_ready_i)
	);

	assign s0_ar_addr_o = s_ar[0].addr;
	assign s0_ar_id_o = s_ar[0].id;
	assign s0_ar_len_o = s_ar[0].len;
	assign s1_ar_addr_o = s_ar[1].addr;
	assign s1_ar_id_o = s_ar[1].id;
	assign s1_ar_len_o = s_ar[1].len;

	// Return side, one unit per slave
	assign s_beat[0] = '{id: s0_r_id_i, data: s0_r_data_i, resp: s0_r_resp_i, last: s0_r_last_i};
	assign s_beat[1] = '{id: s1_r_id_i, data: s1_r_data_i, resp: s1_r_resp_i, last: s1_r_last_i};

	r_return_unit i_r_s0 (
		.clk(clk), .rstn(rstn),
		.r_valid_i(s0_r_valid_i), .r_beat_i(s_beat[0]),
		.r_ready_o(s0_r_ready_o), .route(r_route[0])
	);

	r_return_unit i_r_s1 (
		.clk(clk), .rstn(rstn),
		.r_valid_i(s1_r_valid_i), .r_beat_i(s_beat[1]),
		.r_ready_o(s1_r_ready_o), .route(r_route[1])
	);

	chan_mux #(.T(r_beat_t), .N_SRC(`XBAR_N_SLAVES), .DEST_IDX(0)) i_r_mux_m0 (
		.clk(clk), .rstn(rstn), .src(r_route),
		.valid_o(m0_r_valid_o), .payload_o(m_beat[0]), .ready_i(m0_r_ready_i)
	);

	chan_mux #(.T(r_beat_t), .N_SRC(`XBAR_N_SLAVES), .DEST_IDX(1)) i_r_mux_m1 (
		.clk(clk), .rstn(rstn), .src(r_route),
		.valid_o(m1_r_valid_o), .payload_o(m_beat[1]), .ready_i(m1_r_ready_i)
	);

	// Master tag dropped on the way out
	assign m0_r_id_o = m_beat[0].id[`XBAR_ID_WIDTH-1:0];
	assign m0_r_data_o = m_beat[0].data;
	assign m0_r_resp_o = m_beat[0].resp;
	assign m0_r_last_o = m_beat[0].last;
	assign m1_r_id_o = m_beat[1].id[`XBAR_ID_WIDTH-1:0];
	assign m1_r_data_o = m_beat[1].data;
	assign m1_r_resp_o = m_beat[1].resp;
	assign m1_r_last_o = m_beat[1].last;

endmodule

// ==== verilog/r_return_unit.sv ====
// ==========================================================
// Per-slave R burst routing FSM back to the tagged master
// ==========================================================
`timescale 1ns/1ns
`include "xbar_settings.svh"

module r_return_unit
	import xbar_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	input  logic      r_valid_i,
	input  r_beat_t   r_beat_i,
	output logic      r_ready_o,
	xbar_route_if.src route
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_CONN
	} state_t;

	state_t      state;
	master_idx_t dest_q;
	master_idx_t beat_tag;
	logic        accepted;

	// Master index sits just above the master's own ID bits
	assign beat_tag = r_beat_i.id[`XBAR_ID_WIDTH +: $bits(master_idx_t)];

	assign accepted = (state != ST_IDLE) && route.accept[dest_q];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (r_valid_i) begin
						state <= ST_REQ;
					end
				end
				// First accept means the master port is ours
				ST_REQ: begin
					if (accepted) begin
						state <= r_beat_i.last ? ST_IDLE : ST_CONN;
					end
				end
				ST_CONN: begin
					if (accepted && r_beat_i.last) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Destination master for the whole burst
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && r_valid_i) begin
			dest_q <= beat_tag;
		end
	end

	// Slave holds the first beat until ready, so req stays up while waiting
	assign route.req = (state == ST_REQ) || (state == ST_CONN && r_valid_i);
	assign route.dest = dest_q;
	assign route.payload = r_beat_i;

	assign r_ready_o = accepted;

	// A slave must not mix bursts of different masters
	a_tag_match: assert property (@(posedge clk) disable iff (!rstn)
		state == ST_CONN && r_valid_i |-> beat_tag == dest_q);

endmodule

// ==== verilog/ar_request_unit.sv ====
// ==========================================================
// Per-master AR capture, ID tagging, decode and issue FSM
// ==========================================================
`timescale 1ns/1ns
`include "xbar_settings.svh"

module ar_request_unit
	import xbar_pkg::*;
#(
	parameter int MASTER_IDX = 0
) (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        ar_valid_i,
	input  logic [`XBAR_ADDR_WIDTH-1:0] ar_addr_i,
	input  logic [`XBAR_ID_WIDTH-1:0]   ar_id_i,
	input  logic [`XBAR_LEN_WIDTH-1:0]  ar_len_i,
	output logic                        ar_ready_o,
	xbar_route_if.src                   route
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_ISSUE
	} state_t;

	state_t     state;
	ar_req_t    req_q;
	slave_idx_t dest_q;
	logic       accepted;

	// Pulse from the mux of the slave this request targets
	assign accepted = route.accept[dest_q];

	// Ready only while no request is held
	assign ar_ready_o = (state == ST_IDLE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ar_valid_i) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					state <= ST_ISSUE;
				end
				ST_ISSUE: begin
					if (accepted) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request is tagged with the master index on capture
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && ar_valid_i) begin
			req_q.addr <= ar_addr_i;
			req_q.id <= {master_idx_t'(MASTER_IDX), ar_id_i};
			req_q.len <= ar_len_i;
		end
		if (state == ST_DECODE) begin
			dest_q <= slave_of_addr(req_q.addr);
		end
	end

	assign route.req = (state == ST_ISSUE);
	assign route.dest = dest_q;
	assign route.payload = req_q;

	// Accept answers only a held request, and only from the slave it targets
	a_accept_held: assert property (@(posedge clk) disable iff (!rstn)
		|route.accept |-> route.req && route.accept[dest_q]);

endmodule

// ==== verilog/chan_mux.sv ====
// ==========================================================
// Arbitration and payload mux for one destination port
// ==========================================================
`timescale 1ns/1ns

module chan_mux #(
	parameter type T        = logic,
	parameter int  N_SRC    = 2,
	parameter int  DEST_IDX = 0
) (
	input  logic      clk,
	input  logic      rstn,
	xbar_route_if.mux src [N_SRC],
	output logic      valid_o,
	output T          payload_o,
	input  logic      ready_i
);
	localparam int IDX_W = $clog2(N_SRC);

	logic [N_SRC-1:0] req_vec;
	T                 payload_arr [N_SRC];
	logic             gnt;
	logic [IDX_W-1:0] gnt_id;

	for (genvar i = 0; i < N_SRC; i++) begin : g_src
		// Only sources aimed at this port compete for it
		assign req_vec[i] = src[i].req && (int'(src[i].dest) == DEST_IDX);
		assign payload_arr[i] = src[i].payload;
		assign src[i].accept[DEST_IDX] = valid_o && ready_i && (gnt_id == IDX_W'(i));
	end

	rr_arbiter #(
		.N_REQ(N_SRC)
	) i_arb (
		.clk(clk),
		.rstn(rstn),
		.req_i(req_vec),
		.gnt_o(gnt),
		.gnt_id_o(gnt_id)
	);

	// The grant outlives a dropped request by one cycle, so recheck it
	assign valid_o = gnt && req_vec[gnt_id];
	assign payload_o = payload_arr[gnt_id];

	// Sources hold their request until accept, so a stalled item stays put
	a_payload_hold: assert property (@(posedge clk) disable iff (!rstn)
		valid_o && !ready_i |=> valid_o && $stable(payload_o));

endmodule

// ==== verilog/rr_arbiter.sv ====
// ==========================================================
// Round-robin arbiter, grant registered and held
// ==========================================================
`timescale 1ns/1ns

module rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [N_REQ-1:0]         req_i,
	output logic                     gnt_o,
	output logic [$clog2(N_REQ)-1:0] gnt_id_o
);
	localparam int IDX_W = $clog2(N_REQ);

	logic             low_found;
	logic [IDX_W-1:0] low_id;
	logic             up_found;
	logic [IDX_W-1:0] up_id;
	logic [IDX_W-1:0] next_id;

	// Scan downward so the lowest index wins in both searches
	// gnt_id_o still holds the last grant once the grant has dropped
	always_comb begin
		low_found = 1'b0;
		low_id = '0;
		up_found = 1'b0;
		up_id = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				low_found = 1'b1;
				low_id = IDX_W'(i);
				if (i > int'(gnt_id_o)) begin
					up_found = 1'b1;
					up_id = IDX_W'(i);
				end
			end
		end
	end

	// First request above the last grant, else wrap to the lowest
	assign next_id = up_found ? up_id : low_id;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= 1'b0;
			gnt_id_o <= '0;
		end else if (!gnt_o) begin
			if (low_found) begin
				gnt_o <= 1'b1;
				gnt_id_o <= next_id;
			end
		end else if (!req_i[gnt_id_o]) begin
			gnt_o <= 1'b0;
		end
	end

	// A fresh grant skips the last winner whenever another source asks
	a_rr_fair: assert property (@(posedge clk) disable iff (!rstn)
		!gnt_o && |(req_i & ~(N_REQ'(1) << gnt_id_o)) |=>
			gnt_o && gnt_id_o != $past(gnt_id_o));

endmodule

// ==== verilog/xbar_route_if.sv ====
// ==========================================================
// Routed channel between a source unit and a channel mux
// ==========================================================
`timescale 1ns/1ns

interface xbar_route_if #(
	parameter type T = logic,
	parameter type D = logic
);
	localparam int N_DEST = 1 << $bits(D);

	logic req;
	D     dest;
	T     payload;

	// One accept line per destination mux, only the addressed one pulses
	logic [N_DEST-1:0] accept;

	modport src (
		output req,
		output dest,
		output payload,
		input  accept
	);

	modport mux (
		input  req,
		input  dest,
		input  payload,
		output accept
	);

endinterface

// ==== verilog/xbar_pkg.sv ====
// ==========================================================
// Index, tagged ID, AR request and R beat types
// Address decode function of the crossbar
// ==========================================================
`include "xbar_settings.svh"

package xbar_pkg;

	typedef logic [$clog2(`XBAR_N_MASTERS)-1:0] master_idx_t;
	typedef logic [$clog2(`XBAR_N_SLAVES)-1:0] slave_idx_t;

	// Master index sits above the master's own ID bits
	typedef logic [$bits(master_idx_t)+`XBAR_ID_WIDTH-1:0] tagged_id_t;

	// Read request as seen by a slave
	typedef struct packed {
		logic [`XBAR_ADDR_WIDTH-1:0] addr;
		tagged_id_t                  id;
		logic [`XBAR_LEN_WIDTH-1:0]  len;
	} ar_req_t;

	// One read-data beat on its way back to a master
	typedef struct packed {
		tagged_id_t                  id;
		logic [`XBAR_DATA_WIDTH-1:0] data;
		logic [1:0]                  resp;
		logic                        last;
	} r_beat_t;

	// Top address bits pick the slave
	function automatic slave_idx_t slave_of_addr(input logic [`XBAR_ADDR_WIDTH-1:0] addr);
		return addr[`XBAR_ADDR_WIDTH-1 -: $bits(slave_idx_t)];
	endfunction

endpackage

// ==== verilog/xbar_settings.svh ====
// ==========================================================
// Widths and port counts of the AXI read crossbar
// ==========================================================
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// AXI field widths on the master side
`define XBAR_ADDR_WIDTH 32
`define XBAR_DATA_WIDTH 64
`define XBAR_ID_WIDTH   4
`define XBAR_LEN_WIDTH  8

// Port counts
`define XBAR_N_MASTERS  2
`define XBAR_N_SLAVES   2

`endif
